// File: design/data_path.sv
`timescale 1ns/1ps
`include "debug_config.svh"

module data_path (
    input  logic                    i_clock,
    input  logic                    i_reset,
    input  debug_pkg::dbg_ctrl_t    i_ctrl,
    output debug_pkg::dp_status_t   o_status
);
    import debug_pkg::*;

    logic [3:0][7:0]    im [`IM_WORDS];     // Byte lanes, little endian
    logic [31:0]        dm [`DM_WORDS];
    logic [31:0]        pc;
    logic               halt;

    instr_t             instr;
    logic [31:0]        imm_ext;
    logic [`RB_AW-1:0]  b_addr;
    logic [31:0]        a_val;
    logic [31:0]        b_val;
    logic [31:0]        ea;
    logic [31:0]        wb_data;
    logic [31:0]        pc_next;
    logic               wb_en;
    logic               dm_we;
    logic               halt_set;
    logic               exec;

    assign instr   = instr_t'(im[pc[`IM_AW-1:0]]);
    assign imm_ext = {{24{instr.imm[7]}}, instr.imm};
    assign ea      = a_val + imm_ext;
    assign exec    = i_ctrl.pc_enable && !halt;

    // ADD and SUB take the second operand from imm, the rest from rd
    assign b_addr = (instr.opcode == OP_ADD || instr.opcode == OP_SUB) ?
                    instr.imm[`RB_AW-1:0] : instr.rd[`RB_AW-1:0];

    register_bank rb0 (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_we        (exec && wb_en),
        .i_waddr     (instr.rd[`RB_AW-1:0]),
        .i_wdata     (wb_data),
        .i_raddr_a   (instr.rs[`RB_AW-1:0]),
        .i_raddr_b   (b_addr),
        .i_raddr_dbg (i_ctrl.rb_addr),
        .o_rdata_a   (a_val),
        .o_rdata_b   (b_val),
        .o_rdata_dbg (o_status.rb_data)
    );

    always_comb begin
        wb_en    = 1'b0;
        wb_data  = ea;
        dm_we    = 1'b0;
        halt_set = 1'b0;
        pc_next  = pc + 32'd1;
        case (instr.opcode)
            OP_ADDI: wb_en = 1'b1;
            OP_ADD: begin
                wb_en   = 1'b1;
                wb_data = a_val + b_val;
            end
            OP_SUB: begin
                wb_en   = 1'b1;
                wb_data = a_val - b_val;
            end
            OP_LW: begin
                wb_en   = 1'b1;
                wb_data = dm[ea[`DM_AW-1:0]];
            end
            OP_SW: dm_we = 1'b1;
            OP_BEQ: begin
                if (a_val == b_val)
                    pc_next = pc + 32'd1 + imm_ext;
            end
            OP_HLT: begin
                halt_set = 1'b1;
                pc_next  = pc;
            end
            default: ;  // Unknown opcodes behave as NOP
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (i_ctrl.im_we)
            im[i_ctrl.im_byte_addr[7:2]][i_ctrl.im_byte_addr[1:0]] <= i_ctrl.im_data;
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            for (int i = 0; i < `DM_WORDS; i++)
                dm[i] <= '0;
        end else if (exec && dm_we) begin
            dm[ea[`DM_AW-1:0]] <= b_val;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset || i_ctrl.core_restart) begin
            pc   <= '0;
            halt <= 1'b0;
        end else if (exec) begin
            pc <= pc_next;
            if (halt_set)
                halt <= 1'b1;
        end
    end

    assign o_status.pc      = pc;
    assign o_status.halt    = halt;
    assign o_status.dm_data = dm[i_ctrl.dm_addr];

endmodule

// File: design/debug_config.svh
`ifndef DEBUG_CONFIG_SVH
`define DEBUG_CONFIG_SVH

// UART bit period in system clocks
`define CLKS_PER_BIT 16

`define IM_WORDS 64
`define IM_AW    6

`define DM_WORDS 16
`define DM_AW    4

`define NUM_REGS 8
`define RB_AW    3

// Host commands, ASCII
`define CMD_LOAD 8'h4c
`define CMD_RUN  8'h52
`define CMD_STEP 8'h53

`endif

// File: design/debug_pkg.sv
`include "debug_config.svh"

package debug_pkg;

    typedef enum logic [7:0] {
        OP_NOP  = 8'h00,
        OP_ADDI = 8'h01,
        OP_ADD  = 8'h02,
        OP_SUB  = 8'h03,
        OP_LW   = 8'h04,
        OP_SW   = 8'h05,
        OP_BEQ  = 8'h06,
        OP_HLT  = 8'hff
    } opcode_t;

    // Byte fields from the top down
    typedef struct packed {
        opcode_t            opcode;
        logic [7:0]         rd;
        logic [7:0]         rs;
        logic signed [7:0]  imm;
    } instr_t;

    typedef enum logic [7:0] {
        ST_IDLE       = 8'd0,
        ST_LOAD_COUNT = 8'd1,
        ST_LOAD_BYTE  = 8'd2,
        ST_LOAD_ACK   = 8'd3,
        ST_RUN        = 8'd4,
        ST_STEP       = 8'd5,
        ST_REPORT     = 8'd6,
        ST_SEND_WAIT  = 8'd7
    } du_state_t;

    // Shared by both halves of the UART
    typedef enum logic [1:0] {
        U_IDLE,
        U_START,
        U_DATA,
        U_STOP
    } uart_state_t;

    typedef struct packed {
        logic                   im_we;
        logic [7:0]             im_byte_addr;
        logic [7:0]             im_data;
        logic                   pc_enable;
        logic                   core_restart;
        logic [`RB_AW-1:0]      rb_addr;
        logic [`DM_AW-1:0]      dm_addr;
    } dbg_ctrl_t;

    typedef struct packed {
        logic [31:0]    pc;         // Word index
        logic           halt;
        logic [31:0]    rb_data;
        logic [31:0]    dm_data;
    } dp_status_t;

endpackage

// File: design/debug_unit.sv
`timescale 1ns/1ps
`include "debug_config.svh"

module debug_unit (
    input  logic                    i_clock,
    input  logic                    i_reset,
    input  logic                    i_rx_done,
    input  logic [7:0]              i_rx_data,
    input  logic                    i_tx_done,
    input  debug_pkg::dp_status_t   i_status,
    output logic [7:0]              o_tx_data,
    output logic                    o_tx_start,
    output debug_pkg::dbg_ctrl_t    o_ctrl,
    output debug_pkg::du_state_t    o_state
);
    import debug_pkg::*;

    // PC, registers, data memory
    localparam int REPORT_WORDS = 1 + `NUM_REGS + `DM_WORDS;
    localparam int WW = $clog2(REPORT_WORDS);

    du_state_t      state;
    logic [7:0]     load_count;
    logic [7:0]     byte_cnt;
    logic [7:0]     wr_addr;
    logic [7:0]     wr_data;
    logic           im_we;
    logic           core_restart;
    logic           in_report;
    logic [WW-1:0]  word_idx;
    logic [1:0]     lane;
    logic [WW-1:0]  rb_sel;
    logic [WW-1:0]  dm_sel;
    logic [31:0]    report_word;

    assign rb_sel = word_idx - WW'(1);
    assign dm_sel = word_idx - WW'(1 + `NUM_REGS);

    always_comb begin
        if (word_idx == '0)
            report_word = i_status.pc;
        else if (word_idx <= WW'(`NUM_REGS))
            report_word = i_status.rb_data;
        else
            report_word = i_status.dm_data;
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state        <= ST_IDLE;
            o_tx_start   <= 1'b0;
            im_we        <= 1'b0;
            core_restart <= 1'b0;
            in_report    <= 1'b0;
            word_idx     <= '0;
            lane         <= '0;
            byte_cnt     <= '0;
        end else begin
            o_tx_start   <= 1'b0;
            im_we        <= 1'b0;
            core_restart <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (i_rx_done) begin
                        case (i_rx_data)
                            `CMD_LOAD: state <= ST_LOAD_COUNT;
                            `CMD_RUN:  state <= ST_RUN;
                            `CMD_STEP: state <= ST_STEP;
                            default:   state <= ST_IDLE;
                        endcase
                    end
                end
                ST_LOAD_COUNT: begin
                    if (i_rx_done) begin
                        load_count <= i_rx_data;
                        byte_cnt   <= '0;
                        state      <= (i_rx_data == 8'd0) ? ST_LOAD_ACK : ST_LOAD_BYTE;
                    end
                end
                ST_LOAD_BYTE: begin
                    if (i_rx_done) begin
                        wr_addr  <= byte_cnt;
                        wr_data  <= i_rx_data;
                        im_we    <= 1'b1;
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_cnt + 8'd1 == load_count)
                            state <= ST_LOAD_ACK;
                    end
                end
                ST_LOAD_ACK: begin
                    o_tx_data    <= load_count;
                    o_tx_start   <= 1'b1;
                    core_restart <= 1'b1; // PC and halt back to zero
                    in_report    <= 1'b0;
                    state        <= ST_SEND_WAIT;
                end
                ST_RUN: begin
                    if (i_status.halt) begin
                        word_idx <= '0;
                        lane     <= '0;
                        state    <= ST_REPORT;
                    end
                end
                ST_STEP: begin
                    word_idx <= '0;
                    lane     <= '0;
                    state    <= ST_REPORT;
                end
                ST_REPORT: begin
                    o_tx_data  <= report_word[lane*8 +: 8];
                    o_tx_start <= 1'b1;
                    in_report  <= 1'b1;
                    state      <= ST_SEND_WAIT;
                end
                default: begin
                    if (i_tx_done) begin
                        if (!in_report) begin
                            state <= ST_IDLE;
                        end else if (lane != 2'd3) begin
                            lane  <= lane + 1'b1;
                            state <= ST_REPORT;
                        end else if (word_idx == WW'(REPORT_WORDS - 1)) begin
                            state <= ST_IDLE;
                        end else begin
                            lane     <= '0;
                            word_idx <= word_idx + 1'b1;
                            state    <= ST_REPORT;
                        end
                    end
                end
            endcase
        end
    end

    // One cycle in ST_STEP gives exactly one instruction
    always_comb begin
        o_ctrl.im_we        = im_we;
        o_ctrl.im_byte_addr = wr_addr;
        o_ctrl.im_data      = wr_data;
        o_ctrl.pc_enable    = (state == ST_RUN) || (state == ST_STEP);
        o_ctrl.core_restart = core_restart;
        o_ctrl.rb_addr      = rb_sel[`RB_AW-1:0];
        o_ctrl.dm_addr      = dm_sel[`DM_AW-1:0];
    end

    assign o_state = state;

endmodule

// File: design/register_bank.sv
`timescale 1ns/1ps
`include "debug_config.svh"

module register_bank (
    input  logic                i_clock,
    input  logic                i_reset,
    input  logic                i_we,
    input  logic [`RB_AW-1:0]   i_waddr,
    input  logic [31:0]         i_wdata,
    input  logic [`RB_AW-1:0]   i_raddr_a,
    input  logic [`RB_AW-1:0]   i_raddr_b,
    input  logic [`RB_AW-1:0]   i_raddr_dbg,
    output logic [31:0]         o_rdata_a,
    output logic [31:0]         o_rdata_b,
    output logic [31:0]         o_rdata_dbg
);

    logic [31:0] regs [`NUM_REGS];

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            for (int i = 0; i < `NUM_REGS; i++)
                regs[i] <= '0;
        end else if (i_we && i_waddr != '0) begin
            regs[i_waddr] <= i_wdata; // r0 stays zero
        end
    end

    assign o_rdata_a   = regs[i_raddr_a];
    assign o_rdata_b   = regs[i_raddr_b];
    assign o_rdata_dbg = regs[i_raddr_dbg];

endmodule

// File: design/top.sv
`timescale 1ns/1ps

module top (
    input  logic                    i_clock,
    input  logic                    i_reset,
    input  logic                    i_uart_du_rx,
    output logic                    o_uart_du_tx,
    output logic                    o_hlt,
    output debug_pkg::du_state_t    o_state
);
    import debug_pkg::*;

    logic [7:0]     uart_du_received;
    logic           uart_du_rx_done;
    logic [7:0]     uart_du_to_send;
    logic           uart_du_tx_start;
    logic           uart_du_tx_done;
    dbg_ctrl_t      ctrl;
    dp_status_t     status;

    uart_rx uart_rx_1 (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_rx    (i_uart_du_rx),
        .o_data  (uart_du_received),
        .o_done  (uart_du_rx_done)
    );

    uart_tx uart_tx_1 (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_data  (uart_du_to_send),
        .i_start (uart_du_tx_start),
        .o_tx    (o_uart_du_tx),
        .o_done  (uart_du_tx_done)
    );

    debug_unit debug_unit_1 (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .i_rx_done  (uart_du_rx_done),
        .i_rx_data  (uart_du_received),
        .i_tx_done  (uart_du_tx_done),
        .i_status   (status),
        .o_tx_data  (uart_du_to_send),
        .o_tx_start (uart_du_tx_start),
        .o_ctrl     (ctrl),
        .o_state    (o_state)
    );

    data_path data_path_1 (
        .i_clock  (i_clock),
        .i_reset  (i_reset),
        .i_ctrl   (ctrl),
        .o_status (status)
    );

    assign o_hlt = status.halt;

endmodule

// File: design/uart_rx.sv
`timescale 1ns/1ps
`include "debug_config.svh"

module uart_rx (
    input  logic        i_clock,
    input  logic        i_reset,
    input  logic        i_rx,
    output logic [7:0]  o_data,
    output logic        o_done
);
    import debug_pkg::*;

    localparam int CW = $clog2(`CLKS_PER_BIT);

    uart_state_t    state;
    logic [CW-1:0]  cnt;
    logic [2:0]     bit_idx;
    logic [1:0]     rx_sync;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            rx_sync <= 2'b11;
        end else begin
            rx_sync <= {rx_sync[0], i_rx};
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state   <= U_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
            o_done  <= 1'b0;
        end else begin
            o_done <= 1'b0;
            case (state)
                U_IDLE: begin
                    cnt <= '0;
                    if (!rx_sync[1])
                        state <= U_START;
                end
                U_START: begin
                    if (cnt == CW'(`CLKS_PER_BIT / 2 - 1)) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync[1] ? U_IDLE : U_DATA; // Glitch, not a start bit
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                U_DATA: begin
                    if (cnt == CW'(`CLKS_PER_BIT - 1)) begin
                        cnt    <= '0;
                        o_data <= {rx_sync[1], o_data[7:1]}; // LSB first
                        if (bit_idx == 3'd7)
                            state <= U_STOP;
                        else
                            bit_idx <= bit_idx + 1'b1;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    // Mid stop bit
                    if (cnt == CW'(`CLKS_PER_BIT - 1)) begin
                        o_done <= 1'b1;
                        state  <= U_IDLE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

// File: design/uart_tx.sv
`timescale 1ns/1ps
`include "debug_config.svh"

module uart_tx (
    input  logic        i_clock,
    input  logic        i_reset,
    input  logic [7:0]  i_data,
    input  logic        i_start,
    output logic        o_tx,
    output logic        o_done
);
    import debug_pkg::*;

    localparam int CW = $clog2(`CLKS_PER_BIT);

    uart_state_t    state;
    logic [CW-1:0]  cnt;
    logic [2:0]     bit_idx;
    logic [7:0]     shift;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state   <= U_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
            o_tx    <= 1'b1;
            o_done  <= 1'b0;
        end else begin
            o_done <= 1'b0;
            case (state)
                U_IDLE: begin
                    cnt <= '0;
                    if (i_start) begin
                        shift <= i_data;
                        o_tx  <= 1'b0;
                        state <= U_START;
                    end
                end
                U_START: begin
                    if (cnt == CW'(`CLKS_PER_BIT - 1)) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        o_tx    <= shift[0];
                        state   <= U_DATA;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                U_DATA: begin
                    if (cnt == CW'(`CLKS_PER_BIT - 1)) begin
                        cnt <= '0;
                        if (bit_idx == 3'd7) begin
                            o_tx  <= 1'b1;
                            state <= U_STOP;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            shift   <= shift >> 1;
                            o_tx    <= shift[1];
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    if (cnt == CW'(`CLKS_PER_BIT - 1)) begin
                        o_done <= 1'b1; // End of stop bit
                        state  <= U_IDLE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

// File: filelist.f
+incdir+design
design/debug_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/debug_unit.sv
design/register_bank.sv
design/data_path.sv
design/top.sv
tests/tb_checker.sv
tests/tb_top.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f filelist.f --top-module tb_top -o tb_top_sim

./obj_dir/tb_top_sim > sim.log 2>&1
cat sim.log

if grep -q ">>> FAIL" sim.log; then
    echo "Simulation failed"
    exit 1
fi
if ! grep -q ">>> PASS" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"

// File: tests/tb_checker.sv
`timescale 1ns/1ps
`include "debug_config.svh"

module tb_checker #(
    parameter int WORDS = 1 + `NUM_REGS + `DM_WORDS
) (
    input  logic                    i_clock,
    input  logic                    i_tx,
    input  logic                    i_hlt,
    input  debug_pkg::du_state_t    i_state,
    input  int                      i_req_id,
    input  int                      i_exp_count,
    input  logic [31:0]             i_exp_words [WORDS],
    input  logic                    i_exp_hlt,
    output int                      o_done_id,
    output int                      o_value_errors,
    output int                      o_link_errors
);
    import debug_pkg::*;

    localparam int IW = $clog2(WORDS);
    // Long enough to cover a whole program load from the host
    localparam int BYTE_TIMEOUT = 200 * 10 * `CLKS_PER_BIT;

    function automatic string word_name(int idx);
        if (idx == 0)
            return "pc";
        if (idx <= `NUM_REGS)
            return $sformatf("r%0d", idx - 1);
        return $sformatf("dm%0d", idx - 1 - `NUM_REGS);
    endfunction

    task automatic report_value(input string name, input logic [31:0] expected,
                                input logic [31:0] got);
        $display("FAILED at %0t: %s expected %h got %h", $time, name, expected, got);
        o_value_errors++;
    endtask

    // Status 0 good frame, 1 no start bit, 2 bad stop bit
    task automatic receive_byte(output logic [7:0] data, output int status);
        int n;
        data   = '0;
        status = 0;
        n      = 0;
        @(negedge i_clock);
        while (i_tx && n < BYTE_TIMEOUT) begin
            @(negedge i_clock);
            n++;
        end
        if (i_tx) begin
            status = 1;
            return;
        end
        repeat (`CLKS_PER_BIT / 2) @(negedge i_clock); // Centre of start bit
        for (int i = 0; i < 8; i++) begin
            repeat (`CLKS_PER_BIT) @(negedge i_clock);
            data = {i_tx, data[7:1]};
        end
        repeat (`CLKS_PER_BIT) @(negedge i_clock);
        if (!i_tx)
            status = 2;
    endtask

    task automatic check_response();
        logic [7:0]  data;
        logic [31:0] word;
        int          status;
        int          n;
        word = '0;
        for (int k = 0; k < i_exp_count; k++) begin
            receive_byte(data, status);
            if (status == 1) begin
                $display("Timeout at %0t: byte %0d of the answer never started", $time, k);
                o_link_errors++;
                return;
            end
            if (status == 2) begin
                $display("Framing error at %0t: byte %0d has no stop bit", $time, k);
                o_link_errors++;
                return;
            end
            word = {data, word[31:8]};  // Bytes arrive low first
            if (i_exp_count == 1) begin
                if (data !== i_exp_words[0][7:0])
                    report_value("ack", {24'd0, i_exp_words[0][7:0]}, {24'd0, data});
            end else if (k % 4 == 3) begin
                if (word !== i_exp_words[IW'(k / 4)])
                    report_value(word_name(k / 4), i_exp_words[IW'(k / 4)], word);
            end
        end
        if (i_hlt !== i_exp_hlt)
            report_value("o_hlt", 32'(i_exp_hlt), 32'(i_hlt));
        // Unit goes idle once the last stop bit ends
        n = 0;
        while (i_state != ST_IDLE && n < 2 * `CLKS_PER_BIT) begin
            @(negedge i_clock);
            n++;
        end
        if (i_state != ST_IDLE)
            report_value("o_state", 32'(ST_IDLE), 32'(i_state));
    endtask

    initial begin
        o_done_id      = 0;
        o_value_errors = 0;
        o_link_errors  = 0;
        forever begin
            @(negedge i_clock);
            if (i_req_id != o_done_id) begin
                check_response();
                o_done_id = i_req_id;
            end
        end
    end

endmodule

// File: tests/tb_top.sv
`timescale 1ns/1ps
`include "debug_config.svh"

module tb_top;
    import debug_pkg::*;

    localparam int NUM_ENTRIES  = 12;
    localparam int REPORT_WORDS = 1 + `NUM_REGS + `DM_WORDS;
    localparam int IW           = $clog2(REPORT_WORDS);
    localparam int WAIT_TIMEOUT = 200 * 10 * `CLKS_PER_BIT;

    typedef struct packed {
        logic [7:0]         cmd;
        logic [7:0]         nbytes;     // Load length, unused otherwise
        logic [0:11][31:0]  prog;
    } entry_t;

    logic           clock;
    logic           reset;
    logic           rx_line;
    logic           tx_line;
    logic           hlt;
    du_state_t      state;

    entry_t         steps [NUM_ENTRIES];
    logic [31:0]    exp_words [REPORT_WORDS];
    logic           exp_hlt;
    int             exp_count;
    int             req_id;
    int             done_id;
    int             value_errors;
    int             link_errors;
    logic           timed_out;

    // Instruction set model
    logic [31:0]    m_regs [`NUM_REGS];
    logic [31:0]    m_dm [`DM_WORDS];
    logic [31:0]    m_im [`IM_WORDS];
    logic [31:0]    m_pc;
    logic           m_halt;
    logic [31:0]    lfsr = 32'h0061_051d;

    top dut0 (
        .i_clock      (clock),
        .i_reset      (reset),
        .i_uart_du_rx (rx_line),
        .o_uart_du_tx (tx_line),
        .o_hlt        (hlt),
        .o_state      (state)
    );

    tb_checker mon0 (
        .i_clock       (clock),
        .i_tx          (tx_line),
        .i_hlt         (hlt),
        .i_state       (state),
        .i_req_id      (req_id),
        .i_exp_count   (exp_count),
        .i_exp_words   (exp_words),
        .i_exp_hlt     (exp_hlt),
        .o_done_id     (done_id),
        .o_value_errors(value_errors),
        .o_link_errors (link_errors)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    function automatic logic next_random_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]; // x^32 + x^22 + x^2 + x + 1
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [7:0] random_byte();
        logic [7:0] b;
        b = '0;
        for (int i = 0; i < 8; i++)
            b = {b[6:0], next_random_bit()};
        return b;
    endfunction

    function automatic logic [31:0] encode(opcode_t op, int rd, int rs, int imm);
        return {op, 8'(rd), 8'(rs), 8'(imm)};
    endfunction

    function automatic entry_t make_entry(logic [7:0] cmd, int nwords, logic [0:11][31:0] prog);
        entry_t ent;
        ent.cmd    = cmd;
        ent.nbytes = 8'(nwords * 4);
        ent.prog   = prog;
        return ent;
    endfunction

    function automatic void write_reg(logic [2:0] idx, logic [31:0] value);
        if (idx != 3'd0)
            m_regs[idx] = value;
    endfunction

    function automatic void model_step();
        logic [31:0] w;
        logic [31:0] imm;
        logic [31:0] a;
        logic [31:0] ea;
        logic [31:0] next_pc;
        if (m_halt)
            return;
        w       = m_im[m_pc[`IM_AW-1:0]];
        imm     = {{24{w[7]}}, w[7:0]};
        a       = m_regs[w[10:8]];
        ea      = a + imm;
        next_pc = m_pc + 32'd1;
        case (w[31:24])
            OP_ADDI: write_reg(w[18:16], ea);
            OP_ADD:  write_reg(w[18:16], a + m_regs[w[2:0]]);
            OP_SUB:  write_reg(w[18:16], a - m_regs[w[2:0]]);
            OP_LW:   write_reg(w[18:16], m_dm[ea[`DM_AW-1:0]]);
            OP_SW:   m_dm[ea[`DM_AW-1:0]] = m_regs[w[18:16]];
            OP_BEQ: begin
                if (m_regs[w[18:16]] == m_regs[w[10:8]])
                    next_pc = m_pc + 32'd1 + imm;
            end
            OP_HLT: begin
                m_halt  = 1'b1;
                next_pc = m_pc;
            end
            default: ;
        endcase
        m_pc = next_pc;
    endfunction

    task automatic model_reset();
        for (int i = 0; i < `NUM_REGS; i++)
            m_regs[3'(i)] = '0;
        for (int i = 0; i < `DM_WORDS; i++)
            m_dm[4'(i)] = '0;
        for (int i = 0; i < `IM_WORDS; i++)
            m_im[6'(i)] = '0;
        m_pc   = '0;
        m_halt = 1'b0;
    endtask

    task automatic build_table();
        logic [0:11][31:0] prog_a;
        logic [0:11][31:0] prog_b;
        logic [0:11][31:0] prog_c;
        prog_a    = '0;
        prog_a[0] = encode(OP_ADDI, 1, 0, int'(random_byte()));
        prog_a[1] = encode(OP_ADDI, 2, 0, int'(random_byte()));
        prog_a[2] = encode(OP_ADD, 3, 1, 2);
        prog_a[3] = encode(OP_SUB, 4, 3, 1);
        prog_a[4] = encode(OP_ADDI, 0, 1, 5);    // r0 must stay zero
        prog_a[5] = encode(OP_HLT, 0, 0, 0);
        prog_b    = '0;
        prog_b[0] = encode(OP_ADDI, 1, 0, 14);
        prog_b[1] = encode(OP_ADDI, 2, 0, 7);
        prog_b[2] = encode(OP_SW, 2, 1, 3);      // Wraps to dm1
        prog_b[3] = encode(OP_SW, 1, 1, -2);
        prog_b[4] = encode(OP_ADDI, 5, 0, -3);
        prog_b[5] = encode(OP_SW, 5, 5, 0);
        prog_b[6] = encode(OP_LW, 6, 1, 3);
        prog_b[7] = encode(OP_LW, 7, 5, -1);
        prog_b[8] = encode(OP_HLT, 0, 0, 0);
        prog_c    = '0;
        prog_c[0] = encode(OP_ADDI, 1, 0, 3);
        prog_c[1] = encode(OP_ADDI, 2, 0, 3);
        prog_c[2] = encode(OP_BEQ, 1, 2, 1);     // Taken
        prog_c[3] = encode(OP_ADDI, 3, 0, 99);
        prog_c[4] = encode(OP_BEQ, 1, 0, 2);     // Not taken
        prog_c[5] = encode(OP_ADDI, 4, 0, 0);
        prog_c[6] = encode(OP_ADDI, 4, 4, 1);
        prog_c[7] = encode(OP_BEQ, 4, 1, 1);
        prog_c[8] = encode(OP_BEQ, 0, 0, -3);    // Back to word 6
        prog_c[9] = encode(OP_HLT, 0, 0, 0);
        steps[0]  = make_entry(`CMD_LOAD, 6, prog_a);
        steps[1]  = make_entry(`CMD_RUN, 0, '0);
        steps[2]  = make_entry(`CMD_LOAD, 9, prog_b);
        steps[3]  = make_entry(`CMD_RUN, 0, '0);
        steps[4]  = make_entry(`CMD_LOAD, 10, prog_c);
        steps[5]  = make_entry(`CMD_STEP, 0, '0);
        steps[6]  = make_entry(`CMD_STEP, 0, '0);
        steps[7]  = make_entry(`CMD_STEP, 0, '0);
        steps[8]  = make_entry(`CMD_RUN, 0, '0);
        steps[9]  = make_entry(`CMD_STEP, 0, '0);
        steps[10] = make_entry(`CMD_LOAD, 10, prog_c);
        steps[11] = make_entry(`CMD_STEP, 0, '0);
    endtask

    task automatic prepare_expected(input entry_t ent);
        if (ent.cmd == `CMD_LOAD) begin
            for (int k = 0; k < int'(ent.nbytes) / 4; k++)
                m_im[6'(k)] = ent.prog[4'(k)];
            m_pc         = '0;
            m_halt       = 1'b0;
            exp_count    = 1;
            exp_words[0] = {24'd0, ent.nbytes};
        end else begin
            if (ent.cmd == `CMD_RUN) begin
                for (int i = 0; i < 1000 && !m_halt; i++)
                    model_step();
            end else begin
                model_step();
            end
            exp_count    = REPORT_WORDS * 4;
            exp_words[0] = m_pc;
            for (int i = 0; i < `NUM_REGS; i++)
                exp_words[IW'(1 + i)] = m_regs[3'(i)];
            for (int i = 0; i < `DM_WORDS; i++)
                exp_words[IW'(1 + `NUM_REGS + i)] = m_dm[4'(i)];
        end
        exp_hlt = m_halt;
    endtask

    // Called 2 ns after a rising edge, returns at the same phase
    task automatic send_byte(input logic [7:0] data);
        logic [9:0] frame;
        frame = {1'b1, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            rx_line = frame[0];
            frame   = frame >> 1;
            repeat (`CLKS_PER_BIT) @(posedge clock);
            #2;
        end
    endtask

    task automatic send_command(input entry_t ent);
        logic [31:0] w;
        send_byte(ent.cmd);
        if (ent.cmd == `CMD_LOAD) begin
            send_byte(ent.nbytes);
            for (int k = 0; k < int'(ent.nbytes) / 4; k++) begin
                w = ent.prog[4'(k)];
                for (int j = 0; j < 4; j++) begin
                    send_byte(w[7:0]); // Low byte first
                    w = w >> 8;
                end
            end
        end
    endtask

    task automatic wait_answer(output logic late);
        int n;
        n = 0;
        while (done_id != req_id && n < WAIT_TIMEOUT) begin
            @(posedge clock);
            n++;
        end
        #2;
        late = (done_id != req_id);
    endtask

    initial begin
        reset     = 1'b1;
        rx_line   = 1'b1;
        req_id    = 0;
        timed_out = 1'b0;
        exp_count = 1;
        exp_hlt   = 1'b0;
        for (int i = 0; i < REPORT_WORDS; i++)
            exp_words[IW'(i)] = '0;
        model_reset();
        build_table();
        repeat (8) @(posedge clock);
        #2;
        reset = 1'b0;
        repeat (4) @(posedge clock);
        #2;
        for (int e = 0; e < NUM_ENTRIES && !timed_out; e++) begin
            prepare_expected(steps[4'(e)]);
            req_id = req_id + 1;
            send_command(steps[4'(e)]);
            wait_answer(timed_out);
            if (timed_out)
                $display("Timeout: the checker never finished the answer to command %0d", e);
        end
        $display("Errors: %0d wrong values, %0d missing or broken bytes, %0d command timeouts",
                 value_errors, link_errors, int'(timed_out));
        if (timed_out || value_errors != 0 || link_errors != 0) begin
            $display(">>> FAIL");
        end else begin
            $display(">>> PASS");
        end
        $finish;
    end

endmodule
